//--- hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    // what the memory stage does with an instruction
    typedef enum logic [2:0] {
        MEM_NONE   = 3'd0,  // no memory access
        MEM_LOAD_S = 3'd1,  // lb, lh, lw
        MEM_LOAD_U = 3'd2,  // lbu, lhu
        MEM_STORE  = 3'd3   // sb, sh, sw
    } mem_kind_t;

    // access width, naturally aligned
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_t;

    // decoded memory operation from execute
    typedef struct packed {
        mem_kind_t kind;
        mem_size_t size;
    } mem_op_t;

    // tag of an instruction in flight
    typedef logic [7:0] inst_id_t;

    // no real instruction carries this id
    localparam inst_id_t INST_ID_NONE = 8'hff;

endpackage

`default_nettype wire

//--- hdl/data_ram.sv
`default_nettype none

module data_ram
    import mem_pkg::*;
#(
    parameter int ADDR_BITS    = 8,
    parameter int READ_LATENCY = 2,   // at least 1
    parameter int BUSY_CYCLES  = 1
) (
    input  logic clk,
    input  logic rst,
    dmem_if.ram  dmem
);

    localparam int DEPTH  = 1 << ADDR_BITS;
    localparam int BUSY_W = $clog2(BUSY_CYCLES + 1) + 1;
    localparam int LAT_W  = $clog2(READ_LATENCY + 1) + 1;

    data_word_u        mem [DEPTH];
    data_word_u        rd_word;     // word read at acceptance

    logic [BUSY_W-1:0] busy_cnt;
    logic [LAT_W-1:0]  lat_cnt;     // nonzero while a read is outstanding
    logic              accept;
    logic              accept_rd;

    // back-pressure: busy period plus any read in flight
    assign dmem.req_ready = busy_cnt == '0 && lat_cnt == '0;

    assign accept    = dmem.req_valid && dmem.req_ready;
    assign accept_rd = accept && !dmem.req_write;

    assign dmem.rsp_rdata = rd_word;

    // storage, lane writes under the mask
    always_ff @(posedge clk) begin
        if (accept) begin
            if (dmem.req_write) begin
                for (int i = 0; i < BYTE_LANES; i++) begin
                    if (dmem.req_mask[i])
                        mem[dmem.req_addr].bytes[i] <= dmem.req_wdata.bytes[i];
                end
            end else begin
                rd_word <= mem[dmem.req_addr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_cnt       <= '0;
            lat_cnt        <= '0;
            dmem.rsp_valid <= 1'b0;
        end else begin
            if (accept)
                busy_cnt <= BUSY_W'(BUSY_CYCLES);
            else if (busy_cnt != '0)
                busy_cnt <= busy_cnt - 1'b1;

            // response lands READ_LATENCY cycles after the accepting cycle
            if (accept_rd) begin
                lat_cnt        <= LAT_W'(READ_LATENCY - 1);
                dmem.rsp_valid <= READ_LATENCY == 1;
            end else begin
                dmem.rsp_valid <= lat_cnt == LAT_W'(1);
                if (lat_cnt != '0)
                    lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/dmem_if.sv
`default_nettype none

interface dmem_if
    import mem_pkg::*;
#(
    parameter int ADDR_BITS = 8
) ();

    // request, stage to ram
    logic                 req_valid;
    logic                 req_write;
    logic [ADDR_BITS-1:0] req_addr;   // word address
    data_word_u           req_wdata;
    byte_mask_t           req_mask;

    // response, ram to stage
    logic                 req_ready;
    logic                 rsp_valid;  // single-cycle pulse per read
    data_word_u           rsp_rdata;

    modport stage (
        output req_valid, req_write, req_addr, req_wdata, req_mask,
        input  req_ready, rsp_valid, rsp_rdata
    );

    modport ram (
        input  req_valid, req_write, req_addr, req_wdata, req_mask,
        output req_ready, rsp_valid, rsp_rdata
    );

endinterface

`default_nettype wire

//--- hdl/load_formatter.sv
`default_nettype none

module load_formatter
    import core_pkg::*;
    import mem_pkg::*;
(
    input  mem_op_t              op,
    input  logic [1:0]           byte_offset,
    input  data_word_u           raw,
    output logic [DATA_BITS-1:0] rdata
);

    logic [7:0]             sel_byte;
    logic [DATA_BITS/2-1:0] sel_half;
    logic                   sign_ext;

    always_comb begin
        sel_byte = raw.bytes[byte_offset];
        sel_half = raw.halves[byte_offset[1]];  // aligned half, bit 0 ignored
        sign_ext = op.kind == MEM_LOAD_S;

        case (op.size)
            SIZE_B: begin
                rdata = {{(DATA_BITS-8){sign_ext & sel_byte[7]}}, sel_byte};
            end
            SIZE_H: begin
                rdata = {{(DATA_BITS/2){sign_ext & sel_half[DATA_BITS/2-1]}}, sel_half};
            end
            default: begin
                rdata = raw.word;  // lw, no extension
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int DATA_BITS  = 32;
    localparam int BYTE_LANES = DATA_BITS / 8;

    // one data word, seen per byte lane, per half or whole
    typedef union packed {
        logic [BYTE_LANES-1:0][7:0]  bytes;
        logic [1:0][DATA_BITS/2-1:0] halves;
        logic [DATA_BITS-1:0]        word;
    } data_word_u;

    // one enable bit per byte lane
    typedef logic [BYTE_LANES-1:0] byte_mask_t;

endpackage

`default_nettype wire

//--- hdl/mem_subsystem.sv
`default_nettype none

module mem_subsystem
    import core_pkg::*;
#(
    parameter int ADDR_BITS    = 8,
    parameter int READ_LATENCY = 2,
    parameter int BUSY_CYCLES  = 1
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        mem_valid,
    input  inst_id_t    mem_inst_id,
    input  mem_op_t     mem_op,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    input  logic        pipeline_flush,

    output logic        wb_valid,
    output inst_id_t    wb_inst_id,
    output logic [31:0] wb_rdata,
    output logic        memory_stall
);

    dmem_if #(.ADDR_BITS(ADDR_BITS)) dmem ();

    memory_stage #(
        .ADDR_BITS (ADDR_BITS)
    ) u_stage (
        .clk            (clk),
        .rst            (rst),
        .mem_valid      (mem_valid),
        .mem_inst_id    (mem_inst_id),
        .mem_op         (mem_op),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .pipeline_flush (pipeline_flush),
        .dmem           (dmem.stage),
        .wb_valid       (wb_valid),
        .wb_inst_id     (wb_inst_id),
        .wb_rdata       (wb_rdata),
        .memory_stall   (memory_stall)
    );

    data_ram #(
        .ADDR_BITS    (ADDR_BITS),
        .READ_LATENCY (READ_LATENCY),
        .BUSY_CYCLES  (BUSY_CYCLES)
    ) u_ram (
        .clk  (clk),
        .rst  (rst),
        .dmem (dmem.ram)
    );

endmodule

`default_nettype wire

//--- hdl/memory_stage.sv
`default_nettype none

module memory_stage
    import core_pkg::*;
    import mem_pkg::*;
#(
    parameter int ADDR_BITS = 8
) (
    input  logic          clk,
    input  logic          rst,

    input  logic          mem_valid,
    input  inst_id_t      mem_inst_id,
    input  mem_op_t       mem_op,
    input  logic [31:0]   mem_addr,
    input  logic [31:0]   mem_wdata,
    input  logic          pipeline_flush,

    dmem_if.stage         dmem,

    output logic          wb_valid,
    output inst_id_t      wb_inst_id,
    output logic [31:0]   wb_rdata,
    output logic          memory_stall
);

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        ISSUE    = 2'd1,  // request out, waiting for ready
        WAIT_RSP = 2'd2   // load accepted, waiting for data
    } state_t;

    state_t     state;
    inst_id_t   saved_id;
    logic       done;       // saved_id has already been executed

    logic       is_mem;
    logic       is_store;
    logic       fresh;
    logic       start;
    logic       rsp_take;

    data_word_u lane_data;
    byte_mask_t lane_mask;

    // captured load, formatted on the way out
    data_word_u raw_word;
    mem_op_t    load_op;
    logic [1:0] load_off;

    assign is_mem   = mem_op.kind != MEM_NONE;
    assign is_store = mem_op.kind == MEM_STORE;

    // an instruction held by stall must not run twice
    assign fresh    = !done || saved_id != mem_inst_id;
    assign start    = mem_valid && is_mem && fresh;
    assign rsp_take = state == WAIT_RSP && dmem.rsp_valid;

    assign memory_stall = mem_valid && (state != IDLE || start);

    store_lane_gen u_lanes (
        .op          (mem_op),
        .byte_offset (mem_addr[1:0]),
        .wdata       (mem_wdata),
        .lanes       (lane_data),
        .mask        (lane_mask)
    );

    // request fields stay stable while stalled, inputs are held upstream
    assign dmem.req_valid = state == ISSUE;
    assign dmem.req_write = is_store;
    assign dmem.req_addr  = mem_addr[ADDR_BITS+1:2];
    assign dmem.req_wdata = lane_data;
    assign dmem.req_mask  = lane_mask;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            saved_id <= INST_ID_NONE;
            done     <= 1'b0;
        end else begin
            if (mem_valid)
                saved_id <= mem_inst_id;

            if (pipeline_flush || !mem_valid || !is_mem) begin
                state <= IDLE;  // abort, late responses get ignored
                done  <= 1'b0;
            end else begin
                case (state)
                    IDLE: begin
                        if (fresh) begin
                            state <= ISSUE;
                            done  <= 1'b0;
                        end
                    end
                    ISSUE: begin
                        if (dmem.req_ready) begin
                            if (is_store) begin
                                state <= IDLE;
                                done  <= 1'b1;
                            end else begin
                                state <= WAIT_RSP;
                            end
                        end
                    end
                    WAIT_RSP: begin
                        if (dmem.rsp_valid) begin
                            state <= IDLE;
                            done  <= 1'b1;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_take && !pipeline_flush) begin
            raw_word <= dmem.rsp_rdata;
            load_op  <= mem_op;
            load_off <= mem_addr[1:0];
        end
    end

    load_formatter u_format (
        .op          (load_op),
        .byte_offset (load_off),
        .raw         (raw_word),
        .rdata       (wb_rdata)
    );

    assign wb_valid   = mem_valid && !pipeline_flush;
    assign wb_inst_id = mem_inst_id;

endmodule

`default_nettype wire

//--- hdl/store_lane_gen.sv
`default_nettype none

module store_lane_gen
    import core_pkg::*;
    import mem_pkg::*;
(
    input  mem_op_t              op,
    input  logic [1:0]           byte_offset,
    input  logic [DATA_BITS-1:0] wdata,
    output data_word_u           lanes,
    output byte_mask_t           mask
);

    always_comb begin
        lanes.word = wdata;
        mask       = '1;

        case (op.size)
            SIZE_B: begin
                lanes.bytes = {BYTE_LANES{wdata[7:0]}};   // same byte on every lane
                mask        = byte_mask_t'(1) << byte_offset;
            end
            SIZE_H: begin
                lanes.halves = {2{wdata[DATA_BITS/2-1:0]}};
                mask         = byte_offset[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                mask = '1;  // full word
            end
        endcase

        // loads never write
        if (op.kind != MEM_STORE)
            mask = '0;
    end

endmodule

`default_nettype wire

//--- mem_subsystem.f
hdl/core_pkg.sv
hdl/mem_pkg.sv
hdl/dmem_if.sv
hdl/load_formatter.sv
hdl/store_lane_gen.sv
hdl/memory_stage.sv
hdl/data_ram.sv
hdl/mem_subsystem.sv
verif/mem_subsystem_properties.sv
verif/mem_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module mem_subsystem_tb \
    -f mem_subsystem.f

out=$(./obj_dir/Vmem_subsystem_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1

//--- verif/mem_subsystem_properties.sv
`default_nettype none

module mem_subsystem_properties
    import mem_pkg::*;
#(
    parameter int ADDR_BITS = 8
) (
    input logic                 clk,
    input logic                 rst,
    input logic                 mem_valid,
    input logic                 pipeline_flush,
    input logic                 memory_stall,
    input logic [1:0]           state,
    input logic                 req_valid,
    input logic                 req_ready,
    input logic                 req_write,
    input logic [ADDR_BITS-1:0] req_addr,
    input data_word_u           req_wdata,
    input byte_mask_t           req_mask,
    input logic                 rsp_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] IDLE     = 2'd0;
    localparam logic [1:0] WAIT_RSP = 2'd2;

    logic abandoned;  // a flushed access may still get its response

    always_ff @(posedge clk) begin
        if (rst)
            abandoned <= 1'b0;
        else if (pipeline_flush && state != IDLE)
            abandoned <= 1'b1;
        else if (rsp_valid)
            abandoned <= 1'b0;
    end

    held_request: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready && !pipeline_flush |=>
            req_valid && $stable(req_write) && $stable(req_addr)
            && $stable(req_wdata) && $stable(req_mask))
        else $error("request dropped or changed before acceptance");

    rsp_when_waiting: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> state == WAIT_RSP || abandoned)
        else $error("read response outside WAIT_RSP");

    // after a gap any stall comes from a fresh start in IDLE
    no_stall_idle: assert property (@(posedge clk) disable iff (rst)
        !mem_valid |=> !memory_stall || state == IDLE)
        else $error("memory_stall from an access left over after mem_valid dropped");

endmodule

bind memory_stage mem_subsystem_properties #(
    .ADDR_BITS (ADDR_BITS)
) u_props (
    .clk            (clk),
    .rst            (rst),
    .mem_valid      (mem_valid),
    .pipeline_flush (pipeline_flush),
    .memory_stall   (memory_stall),
    .state          (state),
    .req_valid      (dmem.req_valid),
    .req_ready      (dmem.req_ready),
    .req_write      (dmem.req_write),
    .req_addr       (dmem.req_addr),
    .req_wdata      (dmem.req_wdata),
    .req_mask       (dmem.req_mask),
    .rsp_valid      (dmem.rsp_valid)
);

`default_nettype wire

//--- verif/mem_subsystem_tb.sv
`default_nettype none

module mem_subsystem_tb
    import core_pkg::*;
    import mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int READ_LATENCY  = 2;
    localparam int BUSY_CYCLES   = 4;   // long enough to back-pressure the next access
    localparam int STALL_TIMEOUT = 200;

    logic        clk;
    logic        rst;
    logic        mem_valid;
    inst_id_t    mem_inst_id;
    mem_op_t     mem_op;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        pipeline_flush;
    logic        wb_valid;
    inst_id_t    wb_inst_id;
    logic [31:0] wb_rdata;
    logic        memory_stall;

    data_word_u  ref_mem [256];  // expected ram contents
    inst_id_t    cur_id;
    int          last_stall;     // stall cycles of the latest access
    int          mismatches;
    int          failures;

    mem_subsystem #(
        .ADDR_BITS    (8),
        .READ_LATENCY (READ_LATENCY),
        .BUSY_CYCLES  (BUSY_CYCLES)
    ) dut (
        .clk            (clk),
        .rst            (rst),
        .mem_valid      (mem_valid),
        .mem_inst_id    (mem_inst_id),
        .mem_op         (mem_op),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .pipeline_flush (pipeline_flush),
        .wb_valid       (wb_valid),
        .wb_inst_id     (wb_inst_id),
        .wb_rdata       (wb_rdata),
        .memory_stall   (memory_stall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_word(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %08h got %08h", $time, name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_id(string name, inst_id_t exp, inst_id_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %02h got %02h", $time, name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %0b got %0b", $time, name, exp, act);
            mismatches++;
        end
    endtask

    task automatic report_failure(string what);
        $display("ERROR at %0t: %s", $time, what);
        failures++;
    endtask

    // a byte or half lands only on its addressed lanes
    function automatic void model_store(mem_size_t size, logic [7:0] idx, logic [1:0] off,
                                        logic [31:0] wd);
        logic [31:0] lane_bits;
        logic [31:0] data;
        case (size)
            SIZE_B: begin
                lane_bits = 32'hff << (8 * off);
                data      = {4{wd[7:0]}};
            end
            SIZE_H: begin
                lane_bits = 32'hffff << (16 * off[1]);
                data      = {2{wd[15:0]}};
            end
            default: begin
                lane_bits = '1;
                data      = wd;
            end
        endcase
        ref_mem[idx].word = (ref_mem[idx].word & ~lane_bits) | (data & lane_bits);
    endfunction

    function automatic logic [31:0] expect_load(mem_kind_t kind, mem_size_t size,
                                                logic [1:0] off, data_word_u w);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(w.word >> (8 * off));
        h = 16'(w.word >> (16 * off[1]));
        case (size)
            SIZE_B:  return (kind == MEM_LOAD_S) ? 32'(signed'(b)) : 32'(b);
            SIZE_H:  return (kind == MEM_LOAD_S) ? 32'(signed'(h)) : 32'(h);
            default: return w.word;
        endcase
    endfunction

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            mem_valid <= 1'b0;
        end
    endtask

    // drives one instruction with a fresh id until stall falls
    task automatic run_access(mem_kind_t kind, mem_size_t size, logic [7:0] idx,
                              logic [1:0] off, logic [31:0] wdata);
        int cycles;
        cur_id = cur_id + 1'b1;
        @(posedge clk);
        mem_valid   <= 1'b1;
        mem_inst_id <= cur_id;
        mem_op      <= '{kind, size};
        mem_addr    <= {22'h0, idx, off};
        mem_wdata   <= wdata;
        cycles = 0;
        @(negedge clk);
        while (memory_stall && cycles < STALL_TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (memory_stall) begin
            $display("memory_stall still high after %0d cycles at %0t", cycles, $time);
            $display("TEST FAILED");
            $finish;
        end else begin
            last_stall = cycles;
        end
    endtask

    task automatic do_store(mem_size_t size, logic [7:0] idx, logic [1:0] off,
                            logic [31:0] wdata);
        run_access(MEM_STORE, size, idx, off, wdata);
        model_store(size, idx, off, wdata);
    endtask

    task automatic do_load(mem_kind_t kind, mem_size_t size, logic [7:0] idx, logic [1:0] off);
        logic [31:0] exp;
        exp = expect_load(kind, size, off, ref_mem[idx]);
        run_access(kind, size, idx, off, 32'h0);
        check_word("wb_rdata", exp, wb_rdata);
        check_id("wb_inst_id", cur_id, wb_inst_id);
        check_flag("wb_valid", 1'b1, wb_valid);
    endtask

    task automatic test_word_store_load();
        logic [7:0] idx;
        idx = 8'($urandom);
        do_store(SIZE_W, idx, 2'd0, $urandom);
        do_load(MEM_LOAD_S, SIZE_W, idx, 2'd0);
    endtask

    task automatic test_partial_stores();
        logic [7:0] idx;
        idx = 8'($urandom);
        do_store(SIZE_W, idx, 2'd0, $urandom);
        for (int off = 0; off < 4; off++) begin
            do_store(SIZE_B, idx, 2'(off), $urandom);
            do_load(MEM_LOAD_S, SIZE_W, idx, 2'd0);
        end
        for (int off = 0; off < 4; off += 2) begin
            do_store(SIZE_H, idx, 2'(off), $urandom);
            do_load(MEM_LOAD_S, SIZE_W, idx, 2'd0);
        end
    endtask

    task automatic test_load_formats();
        logic [7:0] idx;
        for (int pass = 0; pass < 2; pass++) begin
            idx = 8'($urandom);
            // all bytes negative in the first pass and positive in the second
            if (pass == 0)
                do_store(SIZE_W, idx, 2'd0, $urandom | 32'h8080_8080);
            else
                do_store(SIZE_W, idx, 2'd0, $urandom & 32'h7f7f_7f7f);
            for (int off = 0; off < 4; off++) begin
                do_load(MEM_LOAD_S, SIZE_B, idx, 2'(off));
                do_load(MEM_LOAD_U, SIZE_B, idx, 2'(off));
                if (off % 2 == 0) begin
                    do_load(MEM_LOAD_S, SIZE_H, idx, 2'(off));
                    do_load(MEM_LOAD_U, SIZE_H, idx, 2'(off));
                end
            end
        end
    endtask

    task automatic test_stall_once();
        logic [7:0]  idx;
        logic [31:0] first;
        idx   = 8'($urandom);
        first = $urandom;
        idle(6);
        do_store(SIZE_W, idx, 2'd0, first);
        check_word("store stall cycles", 32'd2, last_stall);
        idle(6);
        do_load(MEM_LOAD_S, SIZE_W, idx, 2'd0);
        check_word("load stall cycles", 2 + READ_LATENCY, last_stall);
        idle(6);
        do_store(SIZE_W, idx, 2'd0, ~first);
        repeat (3) begin
            @(posedge clk);
            mem_wdata <= first;  // held id with new data must not be written
            @(negedge clk);
            check_flag("memory_stall", 1'b0, memory_stall);
        end
        do_load(MEM_LOAD_S, SIZE_W, idx, 2'd0);
    endtask

    task automatic test_back_to_back();
        logic [7:0] a;
        logic [7:0] b;
        int         first_stall;
        a = 8'($urandom);
        b = a ^ 8'h80;
        idle(6);
        do_store(SIZE_W, a, 2'd0, $urandom);
        first_stall = last_stall;
        do_store(SIZE_W, b, 2'd0, $urandom);
        if (last_stall <= first_stall)
            report_failure("second store did not wait for req_ready");
        do_load(MEM_LOAD_S, SIZE_W, a, 2'd0);
        do_load(MEM_LOAD_U, SIZE_W, b, 2'd0);
    endtask

    task automatic test_flush();
        logic [7:0] a;
        logic [7:0] b;
        a = 8'($urandom);
        b = a + 8'd1;
        do_store(SIZE_W, a, 2'd0, $urandom);
        do_store(SIZE_W, b, 2'd0, $urandom);
        idle(6);
        cur_id = cur_id + 1'b1;
        @(posedge clk);
        mem_valid   <= 1'b1;
        mem_inst_id <= cur_id;
        mem_op      <= '{MEM_LOAD_U, SIZE_W};
        mem_addr    <= {22'h0, a, 2'b00};
        repeat (2) @(posedge clk);  // read accepted with the response pending
        pipeline_flush <= 1'b1;
        @(negedge clk);
        check_flag("wb_valid", 1'b0, wb_valid);
        @(posedge clk);
        pipeline_flush <= 1'b0;
        mem_valid      <= 1'b0;
        @(negedge clk);
        if (dut.u_stage.state != 2'd0)
            report_failure("stage not idle after the flush");
        do_load(MEM_LOAD_U, SIZE_W, b, 2'd0);  // late response must not leak in
    endtask

    initial begin
        void'($urandom(32'h6560_f40a));
        cur_id         = 8'h00;
        mismatches     = 0;
        failures       = 0;
        last_stall     = 0;
        rst            = 1'b1;
        mem_valid      = 1'b0;
        mem_inst_id    = 8'h00;
        mem_op         = '{MEM_NONE, SIZE_W};
        mem_addr       = 32'h0;
        mem_wdata      = 32'h0;
        pipeline_flush = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        test_word_store_load();
        test_partial_stores();
        test_load_formats();
        test_stall_once();
        test_back_to_back();
        test_flush();
        idle(4);

        $display("mismatches: %0d, other errors: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
